/* tb.f */
fx2_pkg.sv
sample_fifo.sv
fx2_tx_assembler.sv
dac_sample_drain.sv
fx2_rx_serializer.sv
fx2_status_flags.sv
usrp_bus_interface.sv
bus_interface_sva.sv
tb_bus_interface.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and succeed only when the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_bus_interface -f tb.f &&
./obj_dir/Vtb_bus_interface | tee /dev/stderr | grep -qx '>>> PASS' &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

/* tb_bus_interface.sv */
////////////////////////////////////////////////////////////////////////////
// Directed tests of the FX2 bus interface, default parameters only
// Inputs change just after the rising edge and outputs are sampled at the falling edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_bus_interface;

   import fx2_pkg::*;

   // usbctl patterns for a host write and a host read
   localparam logic [5:0] WR_LINES = 6'(1 << CTL_WR);
   localparam logic [5:0] RD_LINES = 6'((1 << CTL_RD) | (1 << CTL_OE));

   // FIFO status bits on the debug bus
   localparam int DBG_TX_EMPTY = 2;
   localparam int DBG_TX_FULL  = 3;
   localparam int DBG_RX_EMPTY = 4;
   localparam int DBG_RX_FULL  = 5;

   // Pop limit for one drain sits above the FIFO depth
   localparam int DRAIN_LIMIT = 4200;

   logic        usbclk;
   logic        reset;
   logic [5:0]  usbctl;
   usb_word_t   usbdata_in;
   usb_word_t   usbdata_out;
   logic        usbdata_oe;
   logic [5:0]  usbrdy;
   sample_t     txdata;
   logic        txstrobe;
   sample_t     rxdata;
   logic        rxstrobe;
   logic        clear_status;
   debug_bus_t  debugbus;

   logic [31:0] rng;
   sample_t     tx_expect[$];
   sample_t     rx_expect[$];
   int          checks;
   int          value_errors;
   int          other_errors;

   usrp_bus_interface uut (
      .usbclk       (usbclk),
      .reset        (reset),
      .usbctl       (usbctl),
      .usbdata_in   (usbdata_in),
      .usbdata_out  (usbdata_out),
      .usbdata_oe   (usbdata_oe),
      .usbrdy       (usbrdy),
      .txdata       (txdata),
      .txstrobe     (txstrobe),
      .rxdata       (rxdata),
      .rxstrobe     (rxstrobe),
      .clear_status (clear_status),
      .debugbus     (debugbus)
   );

   // 100 MHz usbclk
   initial
   begin
      usbclk = 1'b0;
      forever #5 usbclk = ~usbclk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Random source and compare tasks
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check_sample(input string name, input sample_t got, input sample_t exp);
      checks++;
      if (got !== exp)
      begin
         value_errors++;
         $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_word(input string name, input usb_word_t got, input usb_word_t exp);
      checks++;
      if (got !== exp)
      begin
         value_errors++;
         $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         value_errors++;
         $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic report_problem(input string msg);
      other_errors++;
      $display("ERROR t=%0t %s", $time, msg);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus drivers
   // One WR burst of random words
   // Expected samples come from the first 256 words only
   task automatic write_burst(input int n_words);
      usb_word_t word;
      sample_t   pair;
      for (int i = 0; i < n_words; i++)
      begin
         rng  = xorshift32(rng);
         word = rng[15:0];
         @(posedge usbclk);
         usbctl     <= WR_LINES;
         usbdata_in <= word;
         if (i < 256)
         begin
            // Even words are I, odd words Q
            if (i % 2 == 0)
               pair[31:16] = word;
            else
            begin
               pair[15:0] = word;
               tx_expect.push_back(pair);
            end
         end
      end
      @(posedge usbclk);
      usbctl <= 6'b0;
      // Commit follows the last Q edge and the write lands one edge later
      repeat (2) @(posedge usbclk);
   endtask

   // Strobe the DAC side until empty and compare each head
   task automatic drain_tx(input int expect_n);
      int popped;
      popped = 0;
      @(negedge usbclk);
      while (!debugbus[DBG_TX_EMPTY] && popped < DRAIN_LIMIT)
      begin
         if (tx_expect.size() > 0)
            check_sample("txdata", txdata, tx_expect.pop_front());
         else
            report_problem("transmit FIFO holds more samples than were written");
         @(posedge usbclk);
         txstrobe <= 1'b1;
         @(posedge usbclk);
         txstrobe <= 1'b0;
         @(negedge usbclk);
         popped++;
      end
      if (popped >= DRAIN_LIMIT)
         report_problem("timeout, transmit FIFO never went empty");
      if (popped != expect_n)
         report_problem($sformatf("drained %0d samples instead of %0d", popped, expect_n));
      // Muted output once empty
      check_sample("txdata", txdata, '0);
   endtask

   // Back-to-back rxstrobe
   // Only the first keep samples are expected back
   task automatic push_rx(input int n_samples, input int keep);
      for (int i = 0; i < n_samples; i++)
      begin
         rng = xorshift32(rng);
         @(posedge usbclk);
         rxstrobe <= 1'b1;
         rxdata   <= rng;
         if (i < keep)
            rx_expect.push_back(rng);
      end
      @(posedge usbclk);
      rxstrobe <= 1'b0;
      @(negedge usbclk);
   endtask

   // RD held for two cycles per sample with the I word first
   task automatic read_rx(input int n_samples);
      sample_t exp;
      @(posedge usbclk);
      usbctl <= RD_LINES;
      for (int i = 0; i < n_samples; i++)
      begin
         exp = '0;
         if (rx_expect.size() > 0)
            exp = rx_expect.pop_front();
         else
            report_problem("host read past the written receive samples");
         @(negedge usbclk);
         check_word("usbdata_out I", usbdata_out, exp[31:16]);
         // OE is driven with RD for the whole read
         check_bit("usbdata_oe", usbdata_oe, 1'b1);
         @(negedge usbclk);
         check_word("usbdata_out Q", usbdata_out, exp[15:0]);
      end
      @(posedge usbclk);
      usbctl <= 6'b0;
      @(negedge usbclk);
      check_bit("usbdata_oe idle", usbdata_oe, 1'b0);
   endtask

   task automatic clear_flags();
      @(posedge usbclk);
      clear_status <= 1'b1;
      @(posedge usbclk);
      clear_status <= 1'b0;
      @(negedge usbclk);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   task automatic packet_write_drain();
      write_burst(256);
      drain_tx(128);
   endtask

   task automatic burst_overflow_space();
      // Extra 44 words in the same burst are dropped
      write_burst(300);
      drain_tx(128);
      repeat (15) write_burst(256);
      @(negedge usbclk);
      check_bit("have_space at 1920", usbrdy[RDY_SPACE], 1'b1);
      write_burst(256);
      @(negedge usbclk);
      check_bit("have_space at 2048", usbrdy[RDY_SPACE], 1'b0);
      check_bit("tx_full", debugbus[DBG_TX_FULL], 1'b1);
      drain_tx(2048);
   endtask

   task automatic underrun_sticky();
      check_bit("underrun before", usbrdy[RDY_UNDERRUN], 1'b0);
      @(posedge usbclk);
      txstrobe <= 1'b1;
      @(posedge usbclk);
      txstrobe <= 1'b0;
      @(negedge usbclk);
      check_sample("txdata empty", txdata, '0);
      check_bit("underrun set", usbrdy[RDY_UNDERRUN], 1'b1);
      repeat (4) @(posedge usbclk);
      @(negedge usbclk);
      check_bit("underrun held", usbrdy[RDY_UNDERRUN], 1'b1);
      clear_flags();
      check_bit("underrun cleared", usbrdy[RDY_UNDERRUN], 1'b0);
   endtask

   task automatic receive_read();
      check_bit("have_pkt_rdy idle", usbrdy[RDY_PKT], 1'b0);
      push_rx(128, 128);
      check_bit("have_pkt_rdy full packet", usbrdy[RDY_PKT], 1'b1);
      read_rx(128);
      check_bit("have_pkt_rdy after read", usbrdy[RDY_PKT], 1'b0);
      check_bit("rx_empty", debugbus[DBG_RX_EMPTY], 1'b1);
   endtask

   task automatic receive_overrun();
      // Two samples past the depth are lost
      push_rx(2050, 2048);
      check_bit("overrun set", usbrdy[RDY_OVERRUN], 1'b1);
      check_bit("rx_full", debugbus[DBG_RX_FULL], 1'b1);
      read_rx(2048);
      check_bit("rx_empty after overrun", debugbus[DBG_RX_EMPTY], 1'b1);
      check_bit("overrun held", usbrdy[RDY_OVERRUN], 1'b1);
      clear_flags();
      check_bit("overrun cleared", usbrdy[RDY_OVERRUN], 1'b0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Sequence and verdict
   initial
   begin
      rng          = 32'h4e90_a545;
      checks       = 0;
      value_errors = 0;
      other_errors = 0;
      reset        <= 1'b1;
      usbctl       <= 6'b0;
      usbdata_in   <= '0;
      txstrobe     <= 1'b0;
      rxdata       <= '0;
      rxstrobe     <= 1'b0;
      clear_status <= 1'b0;
      repeat (8) @(posedge usbclk);
      reset <= 1'b0;
      @(posedge usbclk);

      packet_write_drain();
      burst_overflow_space();
      underrun_sticky();
      receive_read();
      receive_overrun();

      $display("checks %0d, value errors %0d, other errors %0d",
               checks, value_errors, other_errors);
      if (value_errors + other_errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* bus_interface_sva.sv */
////////////////////////////////////////////////////////////////////////////
// Bus-level invariants, bound into every usrp_bus_interface instance
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bus_interface_sva (
   input wire       usbclk,
   input wire       reset,
   input wire [5:0] usbctl,
   input wire [5:0] usbrdy,
   input wire       usbdata_oe,
   input wire       tx_commit
);

   import fx2_pkg::*;

   // Spare ready lines are tied low
   spare_rdy_low: assert property (@(posedge usbclk) disable iff (reset)
      usbrdy[5:4] == 2'b00)
      else $error("usbrdy[5:4] not zero");

   // One commit per I/Q pair, so never two in a row
   commit_single: assert property (@(posedge usbclk) disable iff (reset)
      tx_commit |=> !tx_commit)
      else $error("tx_commit high on two consecutive cycles");

   // Output enable is a straight copy of OE
   oe_follows: assert property (@(posedge usbclk) disable iff (reset)
      usbdata_oe == usbctl[CTL_OE])
      else $error("usbdata_oe differs from usbctl OE");

endmodule

bind usrp_bus_interface bus_interface_sva bus_checks (
   .usbclk     (usbclk),
   .reset      (reset),
   .usbctl     (usbctl),
   .usbrdy     (usbrdy),
   .usbdata_oe (usbdata_oe),
   .tx_commit  (tx_commit)
);

`default_nettype wire

/* usrp_bus_interface.sv */
////////////////////////////////////////////////////////////////////////////
// All on usbclk; strobes are one-cycle enables and the pad ring owns the tristate
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usrp_bus_interface #(
   parameter int FIFO_DEPTH_LOG2 = 11,
   parameter int TX_SPACE_LIMIT  = 1920,
   parameter int RX_PKT_LINES    = 128
) (
   input  wire                      usbclk,
   input  wire                      reset,
   input  wire [5:0]                usbctl,
   input  wire fx2_pkg::usb_word_t  usbdata_in,
   output wire fx2_pkg::usb_word_t  usbdata_out,
   output wire                      usbdata_oe,
   output wire [5:0]                usbrdy,
   output wire fx2_pkg::sample_t    txdata,
   input  wire                      txstrobe,
   input  wire fx2_pkg::sample_t    rxdata,
   input  wire                      rxstrobe,
   input  wire                      clear_status,
   output wire fx2_pkg::debug_bus_t debugbus
);

   import fx2_pkg::*;

   // Transmit path
   sample_t                  tx_sample;
   logic                     tx_commit;
   logic                     tx_pop;
   sample_t                  tx_head;
   logic                     tx_empty;
   logic                     tx_full;
   logic [FIFO_DEPTH_LOG2:0] tx_level;
   logic                     underrun;

   // Receive path
   logic                     rx_pop;
   sample_t                  rx_head;
   logic                     rx_empty;
   logic                     rx_full;
   logic [FIFO_DEPTH_LOG2:0] rx_level;

   ////////////////////////////////////////////////////////////////////////////
   // Host to DAC
   fx2_tx_assembler tx_asm (
      .usbclk     (usbclk),
      .reset      (reset),
      .usbctl     (usbctl),
      .usbdata_in (usbdata_in),
      .sample     (tx_sample),
      .commit     (tx_commit)
   );

   sample_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) tx_fifo (
      .usbclk  (usbclk),
      .reset   (reset),
      .wr_data (tx_sample),
      .wr_en   (tx_commit),
      .rd_en   (tx_pop),
      .rd_data (tx_head),
      .empty   (tx_empty),
      .full    (tx_full),
      .level   (tx_level)
   );

   dac_sample_drain drain (
      .usbclk       (usbclk),
      .reset        (reset),
      .txstrobe     (txstrobe),
      .head         (tx_head),
      .empty        (tx_empty),
      .clear_status (clear_status),
      .pop          (tx_pop),
      .txdata       (txdata),
      .underrun     (underrun)
   );

   ////////////////////////////////////////////////////////////////////////////
   // ADC to host
   // Full guard on the write side lives in the FIFO
   sample_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) rx_fifo (
      .usbclk  (usbclk),
      .reset   (reset),
      .wr_data (rxdata),
      .wr_en   (rxstrobe),
      .rd_en   (rx_pop),
      .rd_data (rx_head),
      .empty   (rx_empty),
      .full    (rx_full),
      .level   (rx_level)
   );

   fx2_rx_serializer rx_ser (
      .usbclk      (usbclk),
      .reset       (reset),
      .usbctl      (usbctl),
      .head        (rx_head),
      .pop         (rx_pop),
      .usbdata_out (usbdata_out),
      .usbdata_oe  (usbdata_oe)
   );

   // Pop is high exactly in Q phase, so it doubles as the phase bit
   fx2_status_flags #(
      .TX_SPACE_LIMIT  (TX_SPACE_LIMIT),
      .RX_PKT_LINES    (RX_PKT_LINES),
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) status (
      .usbclk       (usbclk),
      .reset        (reset),
      .tx_level     (tx_level),
      .rx_level     (rx_level),
      .tx_empty     (tx_empty),
      .tx_full      (tx_full),
      .rx_empty     (rx_empty),
      .rx_full      (rx_full),
      .rxstrobe     (rxstrobe),
      .txstrobe     (txstrobe),
      .rx_phase_q   (rx_pop),
      .underrun     (underrun),
      .clear_status (clear_status),
      .usbrdy       (usbrdy),
      .debugbus     (debugbus)
   );

endmodule

`default_nettype wire

/* fx2_status_flags.sv */
////////////////////////////////////////////////////////////////////////////
// Thresholds compare registered FIFO levels; usbrdy[5:4] are spare and zero
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fx2_status_flags #(
   parameter int TX_SPACE_LIMIT  = 1920,
   parameter int RX_PKT_LINES    = 128,
   parameter int FIFO_DEPTH_LOG2 = 11
) (
   input  wire                       usbclk,
   input  wire                       reset,
   input  wire [FIFO_DEPTH_LOG2:0]   tx_level,
   input  wire [FIFO_DEPTH_LOG2:0]   rx_level,
   input  wire                       tx_empty,
   input  wire                       tx_full,
   input  wire                       rx_empty,
   input  wire                       rx_full,
   input  wire                       rxstrobe,
   input  wire                       txstrobe,
   input  wire                       rx_phase_q,
   input  wire                       underrun,
   input  wire                       clear_status,
   output logic [5:0]                usbrdy,
   output fx2_pkg::debug_bus_t       debugbus
);

   import fx2_pkg::*;

   // Limits sized to the level bus
   localparam logic [FIFO_DEPTH_LOG2:0] SPACE_LIMIT =
      (FIFO_DEPTH_LOG2+1)'(TX_SPACE_LIMIT);
   localparam logic [FIFO_DEPTH_LOG2:0] PKT_LINES =
      (FIFO_DEPTH_LOG2+1)'(RX_PKT_LINES);

   logic have_space;
   logic have_pkt_rdy;
   logic overrun;

   // Room for one more host packet
   assign have_space   = (tx_level <= SPACE_LIMIT);
   // A whole packet is waiting for the host
   assign have_pkt_rdy = (rx_level >= PKT_LINES);

   // Sticky overrun, a new event beats clear_status
   always_ff @(posedge usbclk or posedge reset)
   begin
      if (reset)
         overrun <= 1'b0;
      else if (rxstrobe && rx_full)
         overrun <= 1'b1;
      else if (clear_status)
         overrun <= 1'b0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Host ready lines
   always_comb
   begin
      usbrdy               = '0;
      usbrdy[RDY_SPACE]    = have_space;
      usbrdy[RDY_PKT]      = have_pkt_rdy;
      usbrdy[RDY_UNDERRUN] = underrun;
      usbrdy[RDY_OVERRUN]  = overrun;
   end

   // Debug bus, same bit order as the older board
   assign debugbus = {have_pkt_rdy,
                      have_space,
                      rxstrobe && !rx_full,
                      rx_phase_q,
                      rxstrobe,
                      txstrobe,
                      rx_full,
                      rx_empty,
                      tx_full,
                      tx_empty,
                      overrun,
                      underrun};

endmodule

`default_nettype wire

/* fx2_rx_serializer.sv */
////////////////////////////////////////////////////////////////////////////
// Host must read I then Q; dropping RD after an I word still pops the sample
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fx2_rx_serializer (
   input  wire                    usbclk,
   input  wire                    reset,
   input  wire [5:0]              usbctl,
   input  wire fx2_pkg::sample_t  head,
   output logic                   pop,
   output fx2_pkg::usb_word_t     usbdata_out,
   output logic                   usbdata_oe
);

   import fx2_pkg::*;

   logic      rd;
   rx_phase_t phase;

   assign rd = usbctl[CTL_RD];

   // Pad ring drives the bus from OE directly
   assign usbdata_oe = usbctl[CTL_OE];

   ////////////////////////////////////////////////////////////////////////////
   // Phase machine
   // First RD cycle shows I, then alternates each edge
   always_ff @(posedge usbclk or posedge reset)
   begin
      if (reset)
         phase <= PHASE_I;
      else if (!rd)
         phase <= PHASE_I;
      else if (phase == PHASE_I)
         phase <= PHASE_Q;
      else
         phase <= PHASE_I;
   end

   // Edge in Q phase retires the sample
   // FIFO ignores this when empty, so the head just repeats
   assign pop = (phase == PHASE_Q);

   // Half-word mux
   always_comb
   begin
      case (phase)
         PHASE_I: usbdata_out = head[31:16];
         default: usbdata_out = head[15:0];
      endcase
   end

endmodule

`default_nettype wire

/* dac_sample_drain.sv */
////////////////////////////////////////////////////////////////////////////
// DAC sees zero while the transmit FIFO is empty
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dac_sample_drain (
   input  wire                    usbclk,
   input  wire                    reset,
   input  wire                    txstrobe,
   input  wire fx2_pkg::sample_t  head,
   input  wire                    empty,
   input  wire                    clear_status,
   output logic                   pop,
   output fx2_pkg::sample_t       txdata,
   output logic                   underrun
);

   import fx2_pkg::*;

   // One pop per strobe, only when there is something to take
   assign pop = txstrobe && !empty;

   // Mute instead of replaying a stale head
   assign txdata = empty ? sample_t'('0) : head;

   // Sticky underrun
   // A new strobe on empty wins over clear_status in the same cycle
   always_ff @(posedge usbclk or posedge reset)
   begin
      if (reset)
         underrun <= 1'b0;
      else if (txstrobe && empty)
         underrun <= 1'b1;
      else if (clear_status)
         underrun <= 1'b0;
   end

endmodule

`default_nettype wire

/* fx2_tx_assembler.sv */
////////////////////////////////////////////////////////////////////////////
// Host words pair up as I then Q; words past 256 in one WR burst are dropped
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fx2_tx_assembler (
   input  wire                      usbclk,
   input  wire                      reset,
   input  wire [5:0]                usbctl,
   input  wire fx2_pkg::usb_word_t  usbdata_in,
   output fx2_pkg::sample_t         sample,
   output logic                     commit
);

   import fx2_pkg::*;

   logic        wr;
   logic        accept;
   word_count_t count;

   assign wr = usbctl[CTL_WR];

   // Stop taking words once a full packet has arrived
   assign accept = wr && !count[$high(count)];

   ////////////////////////////////////////////////////////////////////////////
   // Half-sample register
   always_ff @(posedge usbclk)
   begin
      if (accept)
      begin
         // Even word count is I, odd is Q
         if (count[0])
            sample[15:0] <= usbdata_in;
         else
            sample[31:16] <= usbdata_in;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Burst counter and commit
   always_ff @(posedge usbclk or posedge reset)
   begin
      if (reset)
      begin
         count  <= '0;
         commit <= 1'b0;
      end
      else
      begin
         if (accept)
            count <= count + 1'b1;
         else if (!wr)
            count <= '0;
         // Held at 256 while WR stays high

         // Q word just stored, so the pair is complete next cycle
         // FIFO takes the sample on the edge that ends the pulse
         commit <= accept && count[0];
      end
   end

endmodule

`default_nettype wire

/* sample_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// Single clock, show-ahead; writes while full and pops while empty are lost
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
   parameter int FIFO_DEPTH_LOG2 = 11
) (
   input  wire                     usbclk,
   input  wire                     reset,
   input  wire fx2_pkg::sample_t   wr_data,
   input  wire                     wr_en,
   input  wire                     rd_en,
   output fx2_pkg::sample_t        rd_data,
   output logic                    empty,
   output logic                    full,
   output logic [FIFO_DEPTH_LOG2:0] level
);

   import fx2_pkg::*;

   localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

   // Sample storage
   sample_t                    mem [DEPTH];

   logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
   logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
   logic                       do_write;
   logic                       do_read;

   // Level tops out at DEPTH, so its top bit alone marks full
   assign full  = level[FIFO_DEPTH_LOG2];
   assign empty = (level == '0);

   // Guard both sides here so callers can strobe blindly
   assign do_write = wr_en && !full;
   assign do_read  = rd_en && !empty;

   // Show-ahead, head is always visible without a read request
   assign rd_data = mem[rd_ptr];

   ////////////////////////////////////////////////////////////////////////////
   // Storage
   always_ff @(posedge usbclk)
   begin
      if (do_write)
         mem[wr_ptr] <= wr_data;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Pointers and occupancy
   always_ff @(posedge usbclk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end
      else
      begin
         // Pointers wrap naturally at the power of two depth
         if (do_write)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_read)
            rd_ptr <= rd_ptr + 1'b1;

         // Simultaneous push and pop leave the level alone
         case ({do_write, do_read})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

endmodule

`default_nettype wire

/* fx2_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Types and bit positions shared by the FX2 bus interface
// I is always carried in the upper half of a sample
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package fx2_pkg;

   // One 16-bit word on the host bus
   typedef logic [15:0] usb_word_t;

   // One I/Q sample, I in [31:16] and Q in [15:0]
   typedef logic [31:0] sample_t;

   // Words taken in the current WR burst
   // Top bit set means the 256-word packet is complete
   typedef logic [8:0]  word_count_t;

   // Debug bus for the logic analyser header
   typedef logic [11:0] debug_bus_t;

   // Bit positions in usbctl
   localparam int unsigned CTL_WR = 0;
   localparam int unsigned CTL_RD = 1;
   localparam int unsigned CTL_OE = 2;

   // Bit positions in usbrdy
   localparam int unsigned RDY_SPACE    = 0;
   localparam int unsigned RDY_PKT      = 1;
   localparam int unsigned RDY_UNDERRUN = 2;
   localparam int unsigned RDY_OVERRUN  = 3;

   // Which half of the receive head goes out on the host bus
   typedef enum logic
   {
      PHASE_I = 1'b0,
      PHASE_Q = 1'b1
   } rx_phase_t;

endpackage

`default_nettype wire
